// File: common/isa_pkg.sv
package isa_pkg;

    // exception cause raised in the memory stage
    typedef enum logic [3:0] {
        exc_none = 4'd0,
        exc_int  = 4'd1,
        exc_adel = 4'd2,
        exc_ades = 4'd3,
        exc_sys  = 4'd4,
        exc_bp   = 4'd5,
        exc_ri   = 4'd6,
        exc_ov   = 4'd7
    } except_code_t;

    // general register index
    typedef logic [4:0] reg_addr_t;

endpackage

// File: common/pipe_pkg.sv
package pipe_pkg;

    // writeback control flow
    typedef enum logic [1:0] {
        ctrl_run      = 2'd0,
        // memory stage holding both lanes
        ctrl_stall    = 2'd1,
        // one cycle after an exception, both lanes flushed
        ctrl_redirect = 2'd2
    } ctrl_state_t;

endpackage

// File: common/wb_defines.svh
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// datapath width, also used for pc and instruction words
`define DATA_W 32

// general register index width
`define REG_AW 5

// number of general registers
`define NUM_REGS 32

`endif

// File: hdl/mem_wb.sv
`timescale 1ns/1ns
`include "wb_defines.svh"

module mem_wb (
    input  logic                clk,
    input  logic                reset,
    input  logic                clear1,
    input  logic                clear2,
    input  logic                ena1,
    input  logic                ena2,

    input  logic                m_master_reg_wen,
    input  isa_pkg::reg_addr_t  m_master_reg_waddr,
    input  logic [`DATA_W-1:0]  m_master_inst,
    input  logic [`DATA_W-1:0]  m_master_pc,
    input  logic [`DATA_W-1:0]  m_master_reg_wdata,

    input  logic                m_slave_reg_wen,
    input  isa_pkg::reg_addr_t  m_slave_reg_waddr,
    input  logic [`DATA_W-1:0]  m_slave_inst,
    input  logic [`DATA_W-1:0]  m_slave_pc,
    input  logic [`DATA_W-1:0]  m_slave_reg_wdata,

    output logic                w_master_reg_wen,
    output isa_pkg::reg_addr_t  w_master_reg_waddr,
    output logic [`DATA_W-1:0]  w_master_inst,
    output logic [`DATA_W-1:0]  w_master_pc,
    output logic [`DATA_W-1:0]  w_master_reg_wdata,

    output logic                w_slave_reg_wen,
    output isa_pkg::reg_addr_t  w_slave_reg_waddr,
    output logic [`DATA_W-1:0]  w_slave_inst,
    output logic [`DATA_W-1:0]  w_slave_pc,
    output logic [`DATA_W-1:0]  w_slave_reg_wdata
);

    // master lane, clear wins over enable and inserts a bubble
    always_ff @(posedge clk) begin
        if (reset || clear1) begin
            w_master_reg_wen   <= 1'b0;
            w_master_reg_waddr <= '0;
            w_master_inst      <= '0;
            w_master_pc        <= '0;
            w_master_reg_wdata <= '0;
        end else if (ena1) begin
            w_master_reg_wen   <= m_master_reg_wen;
            w_master_reg_waddr <= m_master_reg_waddr;
            w_master_inst      <= m_master_inst;
            w_master_pc        <= m_master_pc;
            w_master_reg_wdata <= m_master_reg_wdata;
        end
    end

    // slave lane
    always_ff @(posedge clk) begin
        if (reset || clear2) begin
            w_slave_reg_wen   <= 1'b0;
            w_slave_reg_waddr <= '0;
            w_slave_inst      <= '0;
            w_slave_pc        <= '0;
            w_slave_reg_wdata <= '0;
        end else if (ena2) begin
            w_slave_reg_wen   <= m_slave_reg_wen;
            w_slave_reg_waddr <= m_slave_reg_waddr;
            w_slave_inst      <= m_slave_inst;
            w_slave_pc        <= m_slave_pc;
            w_slave_reg_wdata <= m_slave_reg_wdata;
        end
    end

endmodule

// File: hdl/pipe_ctrl.sv
`timescale 1ns/1ns
`include "wb_defines.svh"

module pipe_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mem_stall,
    input  isa_pkg::except_code_t m_master_except,
    input  isa_pkg::except_code_t m_slave_except,
    input  logic [`DATA_W-1:0]   m_master_pc,
    input  logic [`DATA_W-1:0]   m_slave_pc,

    output logic                 ena1,
    output logic                 ena2,
    output logic                 clear1,
    output logic                 clear2,
    output logic                 except_valid,
    output isa_pkg::except_code_t except_code,
    output logic [`DATA_W-1:0]   except_pc
);

    pipe_pkg::ctrl_state_t state;
    pipe_pkg::ctrl_state_t next_state;

    logic                  take_exc;
    isa_pkg::except_code_t take_code;
    logic [`DATA_W-1:0]    take_pc;

    // lane decisions go to mem_wb in the same cycle
    always_comb begin
        ena1       = 1'b0;
        ena2       = 1'b0;
        clear1     = 1'b0;
        clear2     = 1'b0;
        take_exc   = 1'b0;
        take_code  = isa_pkg::exc_none;
        take_pc    = m_master_pc;
        next_state = state;

        if (state == pipe_pkg::ctrl_redirect) begin
            // flush whatever followed the faulting instruction
            clear1     = 1'b1;
            clear2     = 1'b1;
            next_state = pipe_pkg::ctrl_run;
        end else if (mem_stall) begin
            // hold both lanes, exceptions wait until the stall clears
            next_state = pipe_pkg::ctrl_stall;
        end else if (m_master_except != isa_pkg::exc_none) begin
            // older instruction faults, drop both
            clear1     = 1'b1;
            clear2     = 1'b1;
            take_exc   = 1'b1;
            take_code  = m_master_except;
            take_pc    = m_master_pc;
            next_state = pipe_pkg::ctrl_redirect;
        end else if (m_slave_except != isa_pkg::exc_none) begin
            // master still retires
            ena1       = 1'b1;
            clear2     = 1'b1;
            take_exc   = 1'b1;
            take_code  = m_slave_except;
            take_pc    = m_slave_pc;
            next_state = pipe_pkg::ctrl_redirect;
        end else begin
            ena1       = 1'b1;
            ena2       = 1'b1;
            next_state = pipe_pkg::ctrl_run;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pipe_pkg::ctrl_run;
        end else begin
            state <= next_state;
        end
    end

    // exception report, one cycle after the decision
    always_ff @(posedge clk) begin
        if (reset) begin
            except_valid <= 1'b0;
        end else begin
            except_valid <= take_exc;
        end
    end

    always_ff @(posedge clk) begin
        if (take_exc) begin
            except_code <= take_code;
            except_pc   <= take_pc;
        end
    end

    // slave is younger, so flushing the master always flushes the slave
    clear_order_a: assert property (@(posedge clk) disable iff (reset)
        clear1 |-> clear2);

    // redirect cycle blocks a second report right behind the first
    except_pulse_a: assert property (@(posedge clk) disable iff (reset)
        except_valid |=> !except_valid);

endmodule

// File: hdl/wb_top.sv
`timescale 1ns/1ns
`include "wb_defines.svh"

module wb_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mem_stall,

    input  logic                 m_master_reg_wen,
    input  isa_pkg::reg_addr_t   m_master_reg_waddr,
    input  logic [`DATA_W-1:0]   m_master_inst,
    input  logic [`DATA_W-1:0]   m_master_pc,
    input  logic [`DATA_W-1:0]   m_master_reg_wdata,
    input  isa_pkg::except_code_t m_master_except,

    input  logic                 m_slave_reg_wen,
    input  isa_pkg::reg_addr_t   m_slave_reg_waddr,
    input  logic [`DATA_W-1:0]   m_slave_inst,
    input  logic [`DATA_W-1:0]   m_slave_pc,
    input  logic [`DATA_W-1:0]   m_slave_reg_wdata,
    input  isa_pkg::except_code_t m_slave_except,

    input  isa_pkg::reg_addr_t   ra_m1,
    input  isa_pkg::reg_addr_t   ra_m2,
    input  isa_pkg::reg_addr_t   ra_s1,
    input  isa_pkg::reg_addr_t   ra_s2,

    output logic [`DATA_W-1:0]   rd_m1,
    output logic [`DATA_W-1:0]   rd_m2,
    output logic [`DATA_W-1:0]   rd_s1,
    output logic [`DATA_W-1:0]   rd_s2,

    output logic                 except_valid,
    output isa_pkg::except_code_t except_code,
    output logic [`DATA_W-1:0]   except_pc,

    output logic [`DATA_W-1:0]   w_master_pc,
    output logic [`DATA_W-1:0]   w_slave_pc,
    output logic [`DATA_W-1:0]   w_master_inst,
    output logic [`DATA_W-1:0]   w_slave_inst
);

    logic ena1;
    logic ena2;
    logic clear1;
    logic clear2;

    // writeback stage commit signals
    logic               w_master_reg_wen;
    isa_pkg::reg_addr_t w_master_reg_waddr;
    logic [`DATA_W-1:0] w_master_reg_wdata;
    logic               w_slave_reg_wen;
    isa_pkg::reg_addr_t w_slave_reg_waddr;
    logic [`DATA_W-1:0] w_slave_reg_wdata;

    pipe_ctrl u_pipe_ctrl (
        .clk             (clk),
        .reset           (reset),
        .mem_stall       (mem_stall),
        .m_master_except (m_master_except),
        .m_slave_except  (m_slave_except),
        .m_master_pc     (m_master_pc),
        .m_slave_pc      (m_slave_pc),
        .ena1            (ena1),
        .ena2            (ena2),
        .clear1          (clear1),
        .clear2          (clear2),
        .except_valid    (except_valid),
        .except_code     (except_code),
        .except_pc       (except_pc)
    );

    mem_wb u_mem_wb (
        .clk                (clk),
        .reset              (reset),
        .clear1             (clear1),
        .clear2             (clear2),
        .ena1               (ena1),
        .ena2               (ena2),
        .m_master_reg_wen   (m_master_reg_wen),
        .m_master_reg_waddr (m_master_reg_waddr),
        .m_master_inst      (m_master_inst),
        .m_master_pc        (m_master_pc),
        .m_master_reg_wdata (m_master_reg_wdata),
        .m_slave_reg_wen    (m_slave_reg_wen),
        .m_slave_reg_waddr  (m_slave_reg_waddr),
        .m_slave_inst       (m_slave_inst),
        .m_slave_pc         (m_slave_pc),
        .m_slave_reg_wdata  (m_slave_reg_wdata),
        .w_master_reg_wen   (w_master_reg_wen),
        .w_master_reg_waddr (w_master_reg_waddr),
        .w_master_inst      (w_master_inst),
        .w_master_pc        (w_master_pc),
        .w_master_reg_wdata (w_master_reg_wdata),
        .w_slave_reg_wen    (w_slave_reg_wen),
        .w_slave_reg_waddr  (w_slave_reg_waddr),
        .w_slave_inst       (w_slave_inst),
        .w_slave_pc         (w_slave_pc),
        .w_slave_reg_wdata  (w_slave_reg_wdata)
    );

    regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .we_m  (w_master_reg_wen),
        .wa_m  (w_master_reg_waddr),
        .wd_m  (w_master_reg_wdata),
        .we_s  (w_slave_reg_wen),
        .wa_s  (w_slave_reg_waddr),
        .wd_s  (w_slave_reg_wdata),
        .ra_m1 (ra_m1),
        .ra_m2 (ra_m2),
        .ra_s1 (ra_s1),
        .ra_s2 (ra_s2),
        .rd_m1 (rd_m1),
        .rd_m2 (rd_m2),
        .rd_s1 (rd_s1),
        .rd_s2 (rd_s2)
    );

endmodule

// File: regfile/regfile.sv
`timescale 1ns/1ns
`include "wb_defines.svh"

module regfile (
    input  logic                clk,
    input  logic                reset,

    // master write port
    input  logic                we_m,
    input  logic [`REG_AW-1:0]  wa_m,
    input  logic [`DATA_W-1:0]  wd_m,

    // slave write port
    input  logic                we_s,
    input  logic [`REG_AW-1:0]  wa_s,
    input  logic [`DATA_W-1:0]  wd_s,

    input  logic [`REG_AW-1:0]  ra_m1,
    input  logic [`REG_AW-1:0]  ra_m2,
    input  logic [`REG_AW-1:0]  ra_s1,
    input  logic [`REG_AW-1:0]  ra_s2,

    output logic [`DATA_W-1:0]  rd_m1,
    output logic [`DATA_W-1:0]  rd_m2,
    output logic [`DATA_W-1:0]  rd_s1,
    output logic [`DATA_W-1:0]  rd_s2
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    // qualified write strobes, r0 is never written
    logic wr_m;
    logic wr_s;

    assign wr_s = we_s && (wa_s != '0);
    // slave is younger and overrides a master write to the same register
    assign wr_m = we_m && (wa_m != '0) && !(wr_s && (wa_s == wa_m));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_m) begin
                regs[wa_m] <= wd_m;
            end
            if (wr_s) begin
                regs[wa_s] <= wd_s;
            end
        end
    end

    // read with bypass of the write in flight, slave first
    function automatic logic [`DATA_W-1:0] read_port(
        input logic [`REG_AW-1:0] ra
    );
        logic [`DATA_W-1:0] val;
        if (ra == '0) begin
            val = '0;
        end else if (wr_s && (wa_s == ra)) begin
            val = wd_s;
        end else if (wr_m && (wa_m == ra)) begin
            val = wd_m;
        end else begin
            val = regs[ra];
        end
        return val;
    endfunction

    always_comb begin
        rd_m1 = read_port(ra_m1);
        rd_m2 = read_port(ra_m2);
        rd_s1 = read_port(ra_s1);
        rd_s2 = read_port(ra_s2);
    end

    // write masking on both ports must keep r0 at zero
    r0_zero_a: assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0);

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the writeback testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module tb_wb_top -o sim_wb \
    && ./obj_dir/sim_wb > sim.log 2>&1 \
    || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1

// File: src.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
hdl/pipe_ctrl.sv
hdl/mem_wb.sv
regfile/regfile.sv
hdl/wb_top.sv
test/tb_wb_top.sv

// File: test/tb_wb_top.sv
`timescale 1ns/1ns
`include "wb_defines.svh"

module tb_wb_top;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 3;
    // reset state, dual commit, same address, stall, master exc, slave exc
    localparam int TEST_CYCLES   = 2 + 28 + 4 + 7 + 4 + 4;
    localparam int MARGIN_CYCLES = 40;

    logic                  clk;
    logic                  reset;
    logic                  mem_stall;
    logic                  m_master_reg_wen;
    isa_pkg::reg_addr_t    m_master_reg_waddr;
    logic [`DATA_W-1:0]    m_master_inst;
    logic [`DATA_W-1:0]    m_master_pc;
    logic [`DATA_W-1:0]    m_master_reg_wdata;
    isa_pkg::except_code_t m_master_except;
    logic                  m_slave_reg_wen;
    isa_pkg::reg_addr_t    m_slave_reg_waddr;
    logic [`DATA_W-1:0]    m_slave_inst;
    logic [`DATA_W-1:0]    m_slave_pc;
    logic [`DATA_W-1:0]    m_slave_reg_wdata;
    isa_pkg::except_code_t m_slave_except;
    isa_pkg::reg_addr_t    ra_m1;
    isa_pkg::reg_addr_t    ra_m2;
    isa_pkg::reg_addr_t    ra_s1;
    isa_pkg::reg_addr_t    ra_s2;
    logic [`DATA_W-1:0]    rd_m1;
    logic [`DATA_W-1:0]    rd_m2;
    logic [`DATA_W-1:0]    rd_s1;
    logic [`DATA_W-1:0]    rd_s2;
    logic                  except_valid;
    isa_pkg::except_code_t except_code;
    logic [`DATA_W-1:0]    except_pc;
    logic [`DATA_W-1:0]    w_master_pc;
    logic [`DATA_W-1:0]    w_slave_pc;
    logic [`DATA_W-1:0]    w_master_inst;
    logic [`DATA_W-1:0]    w_slave_inst;

    // expected architectural register contents
    logic [`DATA_W-1:0] model [`NUM_REGS];
    logic [31:0]        rng;
    int                 pass_count;
    int                 fail_count;

    wb_top UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s: done, %0d mismatches", name, fail_count - errs_before);
    endtask

    // register 0 never changes in the model
    task automatic commit(input isa_pkg::reg_addr_t addr, input logic [31:0] data);
        if (addr != 5'd0) begin
            model[addr] = data;
        end
    endtask

    task automatic drive_master(input logic wen, input isa_pkg::reg_addr_t addr,
                                input logic [31:0] data, input logic [31:0] pc,
                                input isa_pkg::except_code_t exc);
        m_master_reg_wen   <= wen;
        m_master_reg_waddr <= addr;
        m_master_reg_wdata <= data;
        m_master_pc        <= pc;
        m_master_inst      <= pc ^ 32'h2400_0000;
        m_master_except    <= exc;
    endtask

    task automatic drive_slave(input logic wen, input isa_pkg::reg_addr_t addr,
                               input logic [31:0] data, input logic [31:0] pc,
                               input isa_pkg::except_code_t exc);
        m_slave_reg_wen   <= wen;
        m_slave_reg_waddr <= addr;
        m_slave_reg_wdata <= data;
        m_slave_pc        <= pc;
        m_slave_inst      <= pc ^ 32'h2400_0000;
        m_slave_except    <= exc;
    endtask

    task automatic drive_idle();
        drive_master(1'b0, 5'd0, 32'd0, 32'd0, isa_pkg::exc_none);
        drive_slave(1'b0, 5'd0, 32'd0, 32'd0, isa_pkg::exc_none);
    endtask

    task automatic set_reads(input isa_pkg::reg_addr_t a, input isa_pkg::reg_addr_t b,
                             input isa_pkg::reg_addr_t c, input isa_pkg::reg_addr_t d);
        ra_m1 <= a;
        ra_m2 <= b;
        ra_s1 <= c;
        ra_s2 <= d;
    endtask

    task automatic check_reads();
        check($sformatf("rd_m1 (r%0d)", ra_m1), rd_m1, model[ra_m1]);
        check($sformatf("rd_m2 (r%0d)", ra_m2), rd_m2, model[ra_m2]);
        check($sformatf("rd_s1 (r%0d)", ra_s1), rd_s1, model[ra_s1]);
        check($sformatf("rd_s2 (r%0d)", ra_s2), rd_s2, model[ra_s2]);
    endtask

    task automatic check_w_pcs(input logic [31:0] mpc, input logic [31:0] spc);
        check("w_master_pc", w_master_pc, mpc);
        check("w_slave_pc", w_slave_pc, spc);
    endtask

    task automatic test_reset_state();
        int errs;
        errs = fail_count;
        @(posedge clk);
        set_reads(5'd0, 5'd1, 5'd17, 5'd31);
        @(negedge clk);
        check_reads();
        check("except_valid", 32'(except_valid), 32'd0);
        check_w_pcs(32'd0, 32'd0);
        report_test("reset state", errs);
    endtask

    task automatic test_dual_commit();
        int errs;
        logic [31:0] md;
        logic [31:0] sd;
        errs = fail_count;
        // master on even, slave on odd registers, r0 included
        for (int i = 0; i < 16; i++) begin
            rng = xorshift(rng);
            md  = rng;
            rng = xorshift(rng);
            sd  = rng;
            @(posedge clk);
            drive_master(1'b1, 5'(2 * i), md, 32'h1000 + 32'(8 * i), isa_pkg::exc_none);
            drive_slave(1'b1, 5'(2 * i + 1), sd, 32'h1004 + 32'(8 * i), isa_pkg::exc_none);
            commit(5'(2 * i), md);
            commit(5'(2 * i + 1), sd);
        end
        @(posedge clk);
        drive_idle();
        repeat (2) @(posedge clk);
        for (int a = 0; a < `NUM_REGS; a += 4) begin
            @(posedge clk);
            set_reads(5'(a), 5'(a + 1), 5'(a + 2), 5'(a + 3));
            @(negedge clk);
            check_reads();
        end
        report_test("dual commit", errs);
    endtask

    task automatic test_same_address();
        int errs;
        logic [31:0] md;
        logic [31:0] sd;
        errs = fail_count;
        rng = xorshift(rng);
        md  = rng;
        rng = xorshift(rng);
        sd  = rng;
        @(posedge clk);
        drive_master(1'b1, 5'd9, md, 32'h2000, isa_pkg::exc_none);
        drive_slave(1'b1, 5'd9, sd, 32'h2004, isa_pkg::exc_none);
        set_reads(5'd9, 5'd9, 5'd9, 5'd9);
        @(negedge clk);
        // not captured yet, old value
        check_reads();
        @(posedge clk);
        drive_idle();
        commit(5'd9, md);
        commit(5'd9, sd);
        @(negedge clk);
        // write-through in the cycle after capture
        check("rd_m1 same address", rd_m1, sd);
        check_reads();
        @(posedge clk);
        @(negedge clk);
        check_reads();
        report_test("same address", errs);
    endtask

    task automatic test_stall_hold();
        int errs;
        logic [31:0] d1m;
        logic [31:0] d1s;
        logic [31:0] d2m;
        logic [31:0] d2s;
        errs = fail_count;
        rng = xorshift(rng);
        d1m = rng;
        rng = xorshift(rng);
        d1s = rng;
        rng = xorshift(rng);
        d2m = rng;
        rng = xorshift(rng);
        d2s = rng;
        @(posedge clk);
        drive_master(1'b1, 5'd3, d1m, 32'h0100, isa_pkg::exc_none);
        drive_slave(1'b1, 5'd4, d1s, 32'h0104, isa_pkg::exc_none);
        set_reads(5'd3, 5'd4, 5'd3, 5'd4);
        @(posedge clk);
        mem_stall <= 1'b1;
        drive_master(1'b1, 5'd3, d2m, 32'h0200, isa_pkg::exc_none);
        drive_slave(1'b1, 5'd4, d2s, 32'h0204, isa_pkg::exc_none);
        commit(5'd3, d1m);
        commit(5'd4, d1s);
        @(negedge clk);
        check_w_pcs(32'h0100, 32'h0104);
        check_reads();
        for (int c = 0; c < 3; c++) begin
            @(posedge clk);
            if (c == 1) begin
                // junk that must never be captured
                drive_master(1'b1, 5'd3, ~d2m, 32'h0300, isa_pkg::exc_none);
                drive_slave(1'b1, 5'd4, ~d2s, 32'h0304, isa_pkg::exc_none);
            end else begin
                drive_master(1'b1, 5'd3, d2m, 32'h0200, isa_pkg::exc_none);
                drive_slave(1'b1, 5'd4, d2s, 32'h0204, isa_pkg::exc_none);
            end
            if (c == 2) begin
                mem_stall <= 1'b0;
            end
            @(negedge clk);
            check_w_pcs(32'h0100, 32'h0104);
            check_reads();
        end
        @(posedge clk);
        drive_idle();
        commit(5'd3, d2m);
        commit(5'd4, d2s);
        @(negedge clk);
        check_w_pcs(32'h0200, 32'h0204);
        check("w_master_inst", w_master_inst, 32'h0200 ^ 32'h2400_0000);
        check("w_slave_inst", w_slave_inst, 32'h0204 ^ 32'h2400_0000);
        check_reads();
        report_test("stall hold", errs);
    endtask

    task automatic test_master_exception();
        int errs;
        errs = fail_count;
        @(posedge clk);
        drive_master(1'b1, 5'd5, 32'hdead_0005, 32'h0300, isa_pkg::exc_ov);
        drive_slave(1'b1, 5'd6, 32'hdead_0006, 32'h0304, isa_pkg::exc_none);
        set_reads(5'd5, 5'd6, 5'd7, 5'd8);
        @(posedge clk);
        // wrong-path pair, lands in the redirect cycle
        drive_master(1'b1, 5'd7, 32'hdead_0007, 32'h0308, isa_pkg::exc_none);
        drive_slave(1'b1, 5'd8, 32'hdead_0008, 32'h030c, isa_pkg::exc_none);
        @(negedge clk);
        check("except_valid", 32'(except_valid), 32'd1);
        check("except_code", 32'(except_code), 32'(isa_pkg::exc_ov));
        check("except_pc", except_pc, 32'h0300);
        check_w_pcs(32'd0, 32'd0);
        check_reads();
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        check("except_valid", 32'(except_valid), 32'd0);
        check_w_pcs(32'd0, 32'd0);
        check_reads();
        @(posedge clk);
        @(negedge clk);
        check_reads();
        report_test("master exception", errs);
    endtask

    task automatic test_slave_exception();
        int errs;
        errs = fail_count;
        @(posedge clk);
        drive_master(1'b1, 5'd10, 32'hbeef_000a, 32'h0400, isa_pkg::exc_none);
        drive_slave(1'b1, 5'd11, 32'hbeef_000b, 32'h0404, isa_pkg::exc_sys);
        set_reads(5'd10, 5'd11, 5'd10, 5'd11);
        @(posedge clk);
        drive_idle();
        commit(5'd10, 32'hbeef_000a);
        @(negedge clk);
        check("except_valid", 32'(except_valid), 32'd1);
        check("except_code", 32'(except_code), 32'(isa_pkg::exc_sys));
        check("except_pc", except_pc, 32'h0404);
        check_w_pcs(32'h0400, 32'd0);
        check_reads();
        @(posedge clk);
        @(negedge clk);
        check("except_valid", 32'(except_valid), 32'd0);
        @(posedge clk);
        @(negedge clk);
        check_reads();
        report_test("slave exception", errs);
    endtask

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        mem_stall  = 1'b0;
        ra_m1      = 5'd0;
        ra_m2      = 5'd0;
        ra_s1      = 5'd0;
        ra_s2      = 5'd0;
        rng        = 32'h5601fbf9;
        pass_count = 0;
        fail_count = 0;
        drive_idle();
        for (int i = 0; i < `NUM_REGS; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        test_reset_state();
        test_dual_commit();
        test_same_address();
        test_stall_hold();
        test_master_exception();
        test_slave_exception();

        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
